// File: hdl/cr_cfg.svh
// ------------------------------
// widths and bit positions for the control register block
// include wherever a width or an SR bit is needed
// ------------------------------
`ifndef CR_CFG_SVH
`define CR_CFG_SVH

// register id code width
`define CR_ID_W 5

// full data word, and the address part of a 48-bit register
`define CR_DATA_W 64
`define CR_ADDR_W 48

// SR bit set on trap entry
`define CR_SR_MODE_BIT 28

// SR bit set by reset, all others clear
`define CR_SR_RESET_BIT 30

`endif

// File: hdl/crPkg.sv
// ------------------------------
// shared types of the control register block
// referenced by scoped name, never imported
// ------------------------------
`include "cr_cfg.svh"

package crPkg;

	// register ids, unlisted codes read as zero
	typedef enum logic [`CR_ID_W-1:0]
	{
		idSr = 0,
		idExsr = 1,
		idPc = 2,
		idLr = 3,
		idSpc = 4,
		idSsp = 5,
		idVbr = 6,
		idGbr = 7,
		idTbr = 8,
		idTea = 9,
		// discard target, nothing stored
		idZzr = 30,
		idImm = 31
	} crId;

	// one write in flight
	typedef struct packed
	{
		crId id;
		logic [`CR_DATA_W-1:0] value;
	} crWrite;

	// per-stage cancel bits
	typedef struct packed
	{
		logic ex1;
		logic ex2;
		logic ex3;
	} crFlush;

	// EXSR as the trap logic sees it
	typedef struct packed
	{
		logic [31:0] savedSr;
		logic [15:0] reserved;
		logic [15:0] cause;
	} exsrFields;

	// raw word for bank and read port, fields for trap entry and return
	typedef union packed
	{
		logic [`CR_DATA_W-1:0] raw;
		exsrFields f;
	} exsrWord;

	// every register as stored
	typedef struct packed
	{
		logic [`CR_DATA_W-1:0] sr;
		exsrWord exsr;
		logic [`CR_DATA_W-1:0] lr;
		logic [`CR_DATA_W-1:0] tea;
		logic [`CR_ADDR_W-1:0] spc;
		logic [`CR_ADDR_W-1:0] ssp;
		logic [`CR_ADDR_W-1:0] vbr;
		logic [`CR_ADDR_W-1:0] gbr;
		logic [`CR_ADDR_W-1:0] tbr;
		// upper bits of VBR and GBR writes land here
		logic [`CR_DATA_W-`CR_ADDR_W-1:0] vbrCm;
		logic [`CR_DATA_W-`CR_ADDR_W-1:0] fpsr;
	} crView;

	// trap unit proposals, overridden by a commit
	typedef struct packed
	{
		logic [`CR_DATA_W-1:0] sr;
		exsrWord exsr;
		logic [`CR_ADDR_W-1:0] spc;
		logic [`CR_DATA_W-1:0] tea;
	} crNext;

endpackage

// File: hdl/crCommitPipe.sv
// ------------------------------
// EX2/EX3/WB staging of control register writes
// flushed writes become ZZR, live ones are forwarded
// ------------------------------
`timescale 1ns/1ns
`include "cr_cfg.svh"

module crCommitPipe
(
	input logic clock,
	input logic arstN,
	input logic hold,
	input crPkg::crWrite ex1Write,
	input crPkg::crFlush flush,
	input crPkg::crId srcId,
	input logic [`CR_DATA_W-1:0] bankValue,
	output logic [`CR_DATA_W-1:0] srcValue,
	output crPkg::crWrite commit
);

	// idle stage content
	localparam crPkg::crWrite IdleWrite = '{id: crPkg::idZzr, value: '0};

	crPkg::crWrite ex2Q;
	crPkg::crWrite ex3Q;
	crPkg::crWrite wbQ;

	// item leaving a stage, cancelled if that stage is flushed
	function automatic crPkg::crWrite stageOut(input crPkg::crWrite item, input logic kill);
		crPkg::crWrite result;
		result = item;
		if (kill)
		begin
			result.id = crPkg::idZzr;
		end
		return result;
	endfunction

	// hold freezes all three stages
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			ex2Q <= IdleWrite;
			ex3Q <= IdleWrite;
			wbQ <= IdleWrite;
		end
		else if (!hold)
		begin
			ex2Q <= stageOut(ex1Write, flush.ex1);
			ex3Q <= stageOut(ex2Q, flush.ex2);
			wbQ <= stageOut(ex3Q, flush.ex3);
		end
	end

	assign commit = wbQ;

	// oldest first, so the youngest live match wins
	always_comb
	begin
		srcValue = bankValue;
		if (wbQ.id == srcId && wbQ.id != crPkg::idZzr)
		begin
			srcValue = wbQ.value;
		end
		if (ex3Q.id == srcId && ex3Q.id != crPkg::idZzr && !flush.ex3)
		begin
			srcValue = ex3Q.value;
		end
		if (ex2Q.id == srcId && ex2Q.id != crPkg::idZzr && !flush.ex2)
		begin
			srcValue = ex2Q.value;
		end
		if (ex1Write.id == srcId && ex1Write.id != crPkg::idZzr && !flush.ex1)
		begin
			srcValue = ex1Write.value;
		end
	end

	// a flushed EX3 item must never reach the bank
	ex3FlushDropped: assert property (
		@(posedge clock) disable iff (!arstN)
		(!hold && flush.ex3) |=> (commit.id == crPkg::idZzr)
	);

endmodule

// File: hdl/crTrapUnit.sv
// ------------------------------
// next SR/EXSR/SPC/TEA for trap entry and return
// purely combinational, the bank applies it
// ------------------------------
`timescale 1ns/1ns
`include "cr_cfg.svh"

module crTrapUnit
(
	input logic trapReq,
	input logic rteReq,
	input logic [15:0] trapCause,
	input logic [`CR_DATA_W-1:0] faultAddr,
	input logic [`CR_ADDR_W-1:0] pc,
	input crPkg::crView view,
	output crPkg::crNext next,
	output logic redirect,
	output logic [`CR_ADDR_W-1:0] redirectPc
);

	always_comb
	begin
		// default is to keep the current values
		next.sr = view.sr;
		next.exsr = view.exsr;
		next.spc = view.spc;
		next.tea = view.tea;

		if (trapReq)
		begin
			// enter supervisor mode
			next.sr[`CR_SR_MODE_BIT] = 1'b1;
			// old SR low half plus cause
			next.exsr.f.savedSr = view.sr[31:0];
			next.exsr.f.reserved = '0;
			next.exsr.f.cause = trapCause;
			// return address and faulting address
			next.spc = pc;
			next.tea = faultAddr;
		end
		else if (rteReq)
		begin
			// restore low half only, high half stays
			next.sr[31:0] = view.exsr.f.savedSr;
		end
	end

	// trap outranks return
	assign redirect = trapReq | rteReq;

	// vector base for traps, saved pc for returns
	assign redirectPc = trapReq ? view.vbr : view.spc;

endmodule

// File: hdl/crBank.sv
// ------------------------------
// control register state and read decode
// WB commits win over trap unit values, hold freezes all
// ------------------------------
`timescale 1ns/1ns
`include "cr_cfg.svh"

module crBank
(
	input logic clock,
	input logic arstN,
	input logic hold,
	input crPkg::crWrite commit,
	input crPkg::crNext next,
	input logic [`CR_ADDR_W-1:0] pc,
	input crPkg::crId srcId,
	output logic [`CR_DATA_W-1:0] bankValue,
	output crPkg::crView view
);

	// zero pad above a 48-bit register
	localparam int PadW = `CR_DATA_W - `CR_ADDR_W;

	crPkg::crView regs;
	crPkg::crView regsNext;

	always_comb
	begin
		// untouched registers keep their value
		regsNext = regs;

		// trap/return proposals, or current values when idle
		regsNext.sr = next.sr;
		regsNext.exsr = next.exsr;
		regsNext.spc = next.spc;
		regsNext.tea = next.tea;

		// committed write overrides the above
		case (commit.id)
			crPkg::idSr:
			begin
				regsNext.sr = commit.value;
			end
			crPkg::idExsr:
			begin
				regsNext.exsr.raw = commit.value;
			end
			crPkg::idLr:
			begin
				regsNext.lr = commit.value;
			end
			crPkg::idTea:
			begin
				regsNext.tea = commit.value;
			end
			crPkg::idSpc:
			begin
				regsNext.spc = commit.value[`CR_ADDR_W-1:0];
			end
			crPkg::idSsp:
			begin
				regsNext.ssp = commit.value[`CR_ADDR_W-1:0];
			end
			crPkg::idTbr:
			begin
				regsNext.tbr = commit.value[`CR_ADDR_W-1:0];
			end
			crPkg::idVbr:
			begin
				// upper bits go to the companion field
				regsNext.vbr = commit.value[`CR_ADDR_W-1:0];
				regsNext.vbrCm = commit.value[`CR_DATA_W-1:`CR_ADDR_W];
			end
			crPkg::idGbr:
			begin
				// FPSR rides above GBR
				regsNext.gbr = commit.value[`CR_ADDR_W-1:0];
				regsNext.fpsr = commit.value[`CR_DATA_W-1:`CR_ADDR_W];
			end
			default:
			begin
				// PC, ZZR, IMM and unused codes dropped
			end
		endcase
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			regs <= '0;
			// SR comes up with only the reset flag
			regs.sr[`CR_SR_RESET_BIT] <= 1'b1;
		end
		else if (!hold)
		begin
			regs <= regsNext;
		end
	end

	assign view = regs;

	// raw read, forwarding is done by the pipe
	always_comb
	begin
		case (srcId)
			crPkg::idSr:
			begin
				bankValue = regs.sr;
			end
			crPkg::idExsr:
			begin
				bankValue = regs.exsr.raw;
			end
			crPkg::idPc:
			begin
				// no stored PC, use the core's live value
				bankValue = {{PadW{1'b0}}, pc};
			end
			crPkg::idLr:
			begin
				bankValue = regs.lr;
			end
			crPkg::idTea:
			begin
				bankValue = regs.tea;
			end
			crPkg::idSpc:
			begin
				bankValue = {{PadW{1'b0}}, regs.spc};
			end
			crPkg::idSsp:
			begin
				bankValue = {{PadW{1'b0}}, regs.ssp};
			end
			crPkg::idTbr:
			begin
				bankValue = {{PadW{1'b0}}, regs.tbr};
			end
			crPkg::idVbr:
			begin
				bankValue = {regs.vbrCm, regs.vbr};
			end
			crPkg::idGbr:
			begin
				bankValue = {regs.fpsr, regs.gbr};
			end
			default:
			begin
				// ZZR, IMM and unknown codes
				bankValue = '0;
			end
		endcase
	end

	// nothing in the register state may move while held
	heldViewStable: assert property (
		@(posedge clock) disable iff (!arstN)
		hold |=> $stable(view)
	);

endmodule

// File: hdl/crSubsystem.sv
// ------------------------------
// control register subsystem top level
// commit pipe, trap unit and bank wired to the core
// ------------------------------
`timescale 1ns/1ns
`include "cr_cfg.svh"

module crSubsystem
(
	input logic clock,
	input logic arstN,
	input logic hold,
	input logic [`CR_ADDR_W-1:0] pc,
	input crPkg::crWrite ex1Write,
	input crPkg::crFlush flush,
	input crPkg::crId srcId,
	input logic trapReq,
	input logic [15:0] trapCause,
	input logic [`CR_DATA_W-1:0] faultAddr,
	input logic rteReq,
	output logic [`CR_DATA_W-1:0] srcValue,
	output crPkg::crView view,
	output logic redirect,
	output logic [`CR_ADDR_W-1:0] redirectPc
);

	// WB-stage write into the bank
	crPkg::crWrite commit;
	// bank read for srcId before forwarding
	logic [`CR_DATA_W-1:0] bankValue;
	// trap/return proposals
	crPkg::crNext next;

	crCommitPipe u_commitPipe
	(
		.clock(clock),
		.arstN(arstN),
		.hold(hold),
		.ex1Write(ex1Write),
		.flush(flush),
		.srcId(srcId),
		.bankValue(bankValue),
		.srcValue(srcValue),
		.commit(commit)
	);

	crTrapUnit u_trapUnit
	(
		.trapReq(trapReq),
		.rteReq(rteReq),
		.trapCause(trapCause),
		.faultAddr(faultAddr),
		.pc(pc),
		.view(view),
		.next(next),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	crBank u_bank
	(
		.clock(clock),
		.arstN(arstN),
		.hold(hold),
		.commit(commit),
		.next(next),
		.pc(pc),
		.srcId(srcId),
		.bankValue(bankValue),
		.view(view)
	);

endmodule

// File: sim/tbCrSubsystem.sv
// ------------------------------
// random testbench for the control register subsystem
// a reference model of the pipe and bank checks every cycle
// ------------------------------
`timescale 1ns/1ns
`include "cr_cfg.svh"

module tbCrSubsystem;

	localparam int ClockPeriod = 8;
	localparam int ResetCycles = 5;
	localparam int SweepCycles = 32;
	localparam int TestCycles = 3000;
	// run length plus some slack
	localparam int TimeoutNs = (ResetCycles + SweepCycles + TestCycles + 100) * ClockPeriod;

	logic clock;
	logic arstN;
	logic hold;
	logic [`CR_ADDR_W-1:0] pc;
	crPkg::crWrite ex1Write;
	crPkg::crFlush flush;
	crPkg::crId srcId;
	logic trapReq;
	logic [15:0] trapCause;
	logic [`CR_DATA_W-1:0] faultAddr;
	logic rteReq;
	logic [`CR_DATA_W-1:0] srcValue;
	crPkg::crView view;
	logic redirect;
	logic [`CR_ADDR_W-1:0] redirectPc;

	// reference model state
	crPkg::crWrite modelEx2;
	crPkg::crWrite modelEx3;
	crPkg::crWrite modelWb;
	crPkg::crView modelView;

	logic [31:0] randState = 32'hf09f_5125;

	crSubsystem u_dut
	(
		.clock(clock),
		.arstN(arstN),
		.hold(hold),
		.pc(pc),
		.ex1Write(ex1Write),
		.flush(flush),
		.srcId(srcId),
		.trapReq(trapReq),
		.trapCause(trapCause),
		.faultAddr(faultAddr),
		.rteReq(rteReq),
		.srcValue(srcValue),
		.view(view),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	// xorshift32
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = randState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		randState = x;
		return x;
	endfunction

	function automatic logic [63:0] randomWord();
		logic [63:0] w;
		w = {nextRandom(), nextRandom()};
		return w;
	endfunction

	// valid, discard and unused ids with SR and EXSR picked more often
	function automatic crPkg::crId pickId();
		logic [31:0] r;
		crPkg::crId id;
		r = nextRandom();
		case (r[3:0])
			4'd10, 4'd11: id = crPkg::idZzr;
			4'd12: id = crPkg::idImm;
			4'd13: id = crPkg::crId'(5'd10 + {1'b0, r[7:4]});
			4'd14: id = crPkg::idSr;
			4'd15: id = crPkg::idExsr;
			default: id = crPkg::crId'({1'b0, r[3:0]});
		endcase
		return id;
	endfunction

	task automatic abortRun();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkWord(input string name, input logic [`CR_DATA_W-1:0] actual,
		input logic [`CR_DATA_W-1:0] expected);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, actual,
				expected);
			abortRun();
		end
	endtask

	task automatic checkView(input crPkg::crView actual, input crPkg::crView expected);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: view is 0x%h, expected 0x%h", $time, actual, expected);
			abortRun();
		end
	endtask

	// pc only matters while redirect is expected
	task automatic checkRedirect(input logic actual, input logic [`CR_ADDR_W-1:0] actualPc,
		input logic expected, input logic [`CR_ADDR_W-1:0] expectedPc);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: redirect is %b, expected %b", $time, actual, expected);
			abortRun();
		end
		else if (expected && actualPc !== expectedPc)
		begin
			$display("** Error at %0t ns: redirectPc is 0x%h, expected 0x%h", $time, actualPc,
				expectedPc);
			abortRun();
		end
	endtask

	// stored value as seen through the read port
	function automatic logic [`CR_DATA_W-1:0] bankRead(input crPkg::crId id);
		logic [`CR_DATA_W-1:0] v;
		case (id)
			crPkg::idSr: v = modelView.sr;
			crPkg::idExsr: v = modelView.exsr.raw;
			crPkg::idPc: v = {16'h0000, pc};
			crPkg::idLr: v = modelView.lr;
			crPkg::idTea: v = modelView.tea;
			crPkg::idSpc: v = {16'h0000, modelView.spc};
			crPkg::idSsp: v = {16'h0000, modelView.ssp};
			crPkg::idTbr: v = {16'h0000, modelView.tbr};
			crPkg::idVbr: v = {modelView.vbrCm, modelView.vbr};
			crPkg::idGbr: v = {modelView.fpsr, modelView.gbr};
			default: v = 64'h0;
		endcase
		return v;
	endfunction

	// youngest live item first, bank last
	function automatic logic [`CR_DATA_W-1:0] expectedSource();
		if (ex1Write.id == srcId && srcId != crPkg::idZzr && !flush.ex1)
			return ex1Write.value;
		if (modelEx2.id == srcId && srcId != crPkg::idZzr && !flush.ex2)
			return modelEx2.value;
		if (modelEx3.id == srcId && srcId != crPkg::idZzr && !flush.ex3)
			return modelEx3.value;
		if (modelWb.id == srcId && srcId != crPkg::idZzr)
			return modelWb.value;
		return bankRead(srcId);
	endfunction

	// model step for the edge that just sampled the current inputs
	task automatic advanceModel();
		crPkg::crView nv;
		if (!hold)
		begin
			nv = modelView;
			if (trapReq)
			begin
				nv.sr[`CR_SR_MODE_BIT] = 1'b1;
				nv.exsr.raw = {modelView.sr[31:0], 16'h0000, trapCause};
				nv.spc = pc;
				nv.tea = faultAddr;
			end
			else if (rteReq)
			begin
				nv.sr[31:0] = modelView.exsr.raw[63:32];
			end
			// WB commit wins over trap values
			case (modelWb.id)
				crPkg::idSr: nv.sr = modelWb.value;
				crPkg::idExsr: nv.exsr.raw = modelWb.value;
				crPkg::idLr: nv.lr = modelWb.value;
				crPkg::idTea: nv.tea = modelWb.value;
				crPkg::idSpc: nv.spc = modelWb.value[47:0];
				crPkg::idSsp: nv.ssp = modelWb.value[47:0];
				crPkg::idTbr: nv.tbr = modelWb.value[47:0];
				crPkg::idVbr:
				begin
					nv.vbr = modelWb.value[47:0];
					nv.vbrCm = modelWb.value[63:48];
				end
				crPkg::idGbr:
				begin
					nv.gbr = modelWb.value[47:0];
					nv.fpsr = modelWb.value[63:48];
				end
				default: ;
			endcase
			modelView = nv;
			// oldest stage moves first
			modelWb = modelEx3;
			if (flush.ex3)
				modelWb.id = crPkg::idZzr;
			modelEx3 = modelEx2;
			if (flush.ex2)
				modelEx3.id = crPkg::idZzr;
			modelEx2 = ex1Write;
			if (flush.ex1)
				modelEx2.id = crPkg::idZzr;
		end
	endtask

	task automatic driveRandom();
		logic [31:0] r;
		logic [63:0] w;
		r = nextRandom();
		// about one cycle in five held
		hold = (r[31:24] < 8'd51);
		flush.ex1 = (r[2:0] == 3'd0);
		flush.ex2 = (r[5:3] == 3'd0);
		flush.ex3 = (r[8:6] == 3'd0);
		ex1Write.id = pickId();
		ex1Write.value = randomWord();
		srcId = pickId();
		w = randomWord();
		pc = w[47:0];
		r = nextRandom();
		// rare requests and sometimes both together
		trapReq = !hold && (r[5:0] == 6'd0 || r[5:0] == 6'd2);
		rteReq = !hold && (r[5:0] == 6'd1 || r[5:0] == 6'd2);
		trapCause = r[31:16];
		faultAddr = randomWord();
	endtask

	task automatic stepEdge();
		@(posedge clock);
		#1;
		advanceModel();
	endtask

	task automatic checkOutputs();
		checkWord("srcValue", srcValue, expectedSource());
		checkView(view, modelView);
		checkRedirect(redirect, redirectPc, trapReq | rteReq,
			trapReq ? modelView.vbr : modelView.spc);
	endtask

	initial
	begin
		#(TimeoutNs);
		$display("watchdog expired before the test sequence finished");
		abortRun();
	end

	initial
	begin
		logic [63:0] sweepWord;
		arstN = 1'b0;
		hold = 1'b0;
		pc = '0;
		ex1Write = '{id: crPkg::idZzr, value: '0};
		flush = '0;
		srcId = crPkg::idZzr;
		trapReq = 1'b0;
		trapCause = '0;
		faultAddr = '0;
		rteReq = 1'b0;
		// model comes up like the DUT after reset
		modelEx2 = '{id: crPkg::idZzr, value: '0};
		modelEx3 = modelEx2;
		modelWb = modelEx2;
		modelView = '0;
		modelView.sr[`CR_SR_RESET_BIT] = 1'b1;
		repeat (ResetCycles) @(posedge clock);
		#1;
		arstN = 1'b1;

		// read every code right after reset while held and idle
		for (int i = 0; i < SweepCycles; i++)
		begin
			stepEdge();
			hold = 1'b1;
			srcId = crPkg::crId'(i[4:0]);
			sweepWord = randomWord();
			pc = sweepWord[63:16];
			#5;
			checkOutputs();
		end

		for (int n = 0; n < TestCycles; n++)
		begin
			stepEdge();
			driveRandom();
			#5;
			checkOutputs();
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: files.f
+incdir+hdl
hdl/crPkg.sv
hdl/crCommitPipe.sv
hdl/crTrapUnit.sv
hdl/crBank.sv
hdl/crSubsystem.sv
sim/tbCrSubsystem.sv

// File: run.sh
#!/bin/sh
# build and run the control register testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbCrSubsystem -f files.f -o simCr
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simCr)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
